/* Bender.yml */
package:
  name: dcache

sources:
  - files:
      - verilog/dcache_pkg.sv
      - verilog/dcache_way_ram.sv
      - verilog/dcache_line_state.sv
      - verilog/dcache_ctrl.sv
      - verilog/dcache_top.sv
  - target: test
    files:
      - test/dcache_checker.sv
      - test/dcache_tb.sv

/* tb.f */
verilog/dcache_pkg.sv
verilog/dcache_way_ram.sv
verilog/dcache_line_state.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
test/dcache_checker.sv
test/dcache_tb.sv

/* test/dcache_checker.sv */
module dcache_checker (
    input logic                    clk_i,
    input logic                    rst_i,
    input logic                    req_valid_i,
    input logic                    stall_i,
    input dcache_pkg::mem_req_t    mem_req_i,
    input logic                    mem_valid_i,
    input logic                    mem_ready_i,
    input dcache_pkg::ctrl_state_e state_i,
    input logic                    hit_i
);

    // Number of failed assertions
    int unsigned fail_count = 0;

    // Memory request held until accepted
    mem_req_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_req_i)
    ) else begin
        $error("mem_req_o changed or dropped before mem_ready_i");
        fail_count++;
    end

    mem_idle_after_reset: assert property (
        @(posedge clk_i) rst_i |=> !mem_valid_i
    ) else begin
        $error("mem_valid_o high in the cycle after reset");
        fail_count++;
    end

    // Hits in idle complete without a stall
    hit_no_stall: assert property (
        @(posedge clk_i) disable iff (rst_i)
        state_i == dcache_pkg::ST_IDLE && req_valid_i && hit_i |-> !stall_i
    ) else begin
        $error("stall_o high on a hit in the idle state");
        fail_count++;
    end

endmodule

/* test/dcache_tb.sv */
module dcache_tb;

    localparam int INDEX_W    = 8;
    localparam int NUM_REQS   = 2000;
    localparam int MAX_CYCLES = NUM_REQS * 16;

    logic                          clk_i;
    logic                          rst_i;
    dcache_pkg::core_req_t         req_i;
    logic                          req_valid_i;
    logic [dcache_pkg::DATA_W-1:0] rdata_o;
    logic                          stall_o;
    dcache_pkg::mem_req_t          mem_req_o;
    logic                          mem_valid_o;
    logic [dcache_pkg::DATA_W-1:0] mem_rdata_i;
    logic                          mem_ready_i;

    // Missing words in the backing store and the expected contents hold their hash
    logic [31:0] mem_words [bit [dcache_pkg::ADDR_W-1:0]];
    logic [31:0] ref_words [bit [dcache_pkg::ADDR_W-1:0]];
    bit          touched   [bit [dcache_pkg::ADDR_W-1:0]];
    int unsigned cycle_count;

    dcache_top #(
        .INDEX_W(INDEX_W)
    ) i_dcache_top (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .rdata_o     (rdata_o),
        .stall_o     (stall_o),
        .mem_req_o   (mem_req_o),
        .mem_valid_o (mem_valid_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ready_i (mem_ready_i)
    );

    bind dcache_top dcache_checker i_checker (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .stall_i     (stall_o),
        .mem_req_i   (mem_req_o),
        .mem_valid_i (mem_valid_o),
        .mem_ready_i (mem_ready_i),
        .state_i     (i_ctrl.state_q),
        .hit_i       (i_ctrl.hit_any)
    );

    function automatic logic [31:0] initial_word(input logic [dcache_pkg::ADDR_W-1:0] addr);
        return ({15'b0, addr} * 32'h9e3779b1) ^ {addr[7:0], addr, 7'h35};
    endfunction

    function automatic logic [31:0] expected_word(input logic [dcache_pkg::ADDR_W-1:0] addr);
        return ref_words.exists(addr) ? ref_words[addr] : initial_word(addr);
    endfunction

    function automatic logic [31:0] memory_word(input logic [dcache_pkg::ADDR_W-1:0] addr);
        return mem_words.exists(addr) ? mem_words[addr] : initial_word(addr);
    endfunction

    function automatic logic [31:0] apply_write(input logic [31:0] old_word,
                                                input logic [31:0] wdata,
                                                input logic [3:0]  mask);
        logic [31:0] lanes;
        lanes = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (old_word & ~lanes) | (wdata & lanes);
    endfunction

    // Half reads and a quarter full-word writes over 24 tags in 4 sets
    function automatic dcache_pkg::core_req_t random_request();
        dcache_pkg::core_req_t req;
        int unsigned           tag;
        int unsigned           index;
        int unsigned           kind;
        tag       = $urandom_range(0, 23) * 21;
        index     = $urandom_range(0, 3) * 61 + 5;
        kind      = $urandom_range(0, 3);
        req.addr  = dcache_pkg::ADDR_W'((tag << INDEX_W) | index);
        req.wdata = $urandom();
        req.mask  = (kind < 2) ? 4'h0 : (kind == 2) ? 4'hf : 4'($urandom_range(1, 15));
        return req;
    endfunction

    task automatic end_with_failure();
        $display("Something failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected 0x%h, got 0x%h", name, expected, actual);
            end_with_failure();
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever begin
            #4 clk_i = ~clk_i;
        end
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk_i);
            cycle_count++;
            if (i_dcache_top.i_checker.fail_count != 0) begin
                $display("A checker assertion failed");
                end_with_failure();
            end
            if (cycle_count > MAX_CYCLES) begin
                $display("Timeout: requests still pending after %0d cycles", MAX_CYCLES);
                end_with_failure();
            end
        end
    end

    // Memory answers after 0 to 3 wait cycles
    initial begin : memory_model
        logic [dcache_pkg::ADDR_W-1:0] addr;
        int unsigned                   wait_left;
        bit                            pending;
        pending   = 1'b0;
        wait_left = 0;
        forever begin
            @(negedge clk_i);
            if (mem_ready_i) begin
                compare_values("mem_valid_o", 32'd1, 32'(mem_valid_o));
                if (mem_req_o.we) begin
                    compare_values("mem_req_o.wdata", expected_word(mem_req_o.addr),
                                   mem_req_o.wdata);
                    mem_words[mem_req_o.addr] = mem_req_o.wdata;
                end else begin
                    compare_values("mem_req_o.addr", 32'(req_i.addr), 32'(mem_req_o.addr));
                    compare_values("mem_rdata_i", expected_word(mem_req_o.addr), mem_rdata_i);
                end
                pending = 1'b0;
                @(posedge clk_i);
                mem_ready_i <= 1'b0;
            end else if (mem_valid_o) begin
                if (!pending) begin
                    pending   = 1'b1;
                    wait_left = $urandom_range(0, 3);
                end
                addr = mem_req_o.addr;
                if (wait_left == 0) begin
                    @(posedge clk_i);
                    mem_ready_i <= 1'b1;
                    mem_rdata_i <= memory_word(addr);
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin : stimulus
        dcache_pkg::core_req_t req;
        bit                    first_cycle;
        void'($urandom(32'h05bfda63));
        rst_i       = 1'b1;
        req_i       = '0;
        req_valid_i = 1'b0;
        mem_rdata_i = '0;
        mem_ready_i = 1'b0;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        compare_values("mem_valid_o", 32'd0, 32'(mem_valid_o));

        for (int n = 0; n < NUM_REQS; n++) begin
            req = random_request();
            @(posedge clk_i);
            req_i       <= req;
            req_valid_i <= 1'b1;
            first_cycle = 1'b1;
            do begin
                @(negedge clk_i);
                // Never-used address cannot hit
                if (first_cycle && req.mask == '0 && !touched.exists(req.addr)) begin
                    compare_values("stall_o", 32'd1, 32'(stall_o));
                end
                first_cycle = 1'b0;
            end while (stall_o);
            if (req.mask == '0) begin
                compare_values("rdata_o", expected_word(req.addr), rdata_o);
            end else begin
                ref_words[req.addr] = apply_write(expected_word(req.addr), req.wdata, req.mask);
            end
            touched[req.addr] = 1'b1;
        end

        @(posedge clk_i);
        req_valid_i <= 1'b0;
        repeat (4) @(posedge clk_i);
        if (i_dcache_top.i_checker.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Checker assertions failed %0d times", i_dcache_top.i_checker.fail_count);
            end_with_failure();
        end
    end

endmodule

/* verilog/dcache_ctrl.sv */
module dcache_ctrl #(
    parameter int INDEX_W = 8
) (
    input  logic                                       clk_i,
    input  logic                                       rst_i,

    // Core side
    input  dcache_pkg::core_req_t                      req_i,
    input  logic                                       req_valid_i,
    output logic [dcache_pkg::DATA_W-1:0]              rdata_o,
    output logic                                       stall_o,

    // Memory side
    output dcache_pkg::mem_req_t                       mem_req_o,
    output logic                                       mem_valid_o,
    input  logic [dcache_pkg::DATA_W-1:0]              mem_rdata_i,
    input  logic                                       mem_ready_i,

    // Set arrays
    output logic [INDEX_W-1:0]                         index_o,
    input  logic [1:0][dcache_pkg::ADDR_W-INDEX_W-1:0] tag_i,
    input  logic [1:0][dcache_pkg::DATA_W-1:0]         data_i,
    input  logic [1:0]                                 valid_i,
    input  logic [1:0]                                 dirty_i,
    input  logic                                       lru_i,
    output logic [1:0]                                 way_we_o,
    output logic [dcache_pkg::MASK_W-1:0]              be_o,
    output logic [dcache_pkg::ADDR_W-INDEX_W-1:0]      wtag_o,
    output logic [dcache_pkg::DATA_W-1:0]              wdata_o,
    output logic                                       upd_o,
    output logic                                       upd_way_o,
    output logic                                       upd_dirty_o,
    output logic                                       touch_o,
    output logic                                       touch_way_o
);

    localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W;

    dcache_pkg::ctrl_state_e state_q;
    dcache_pkg::ctrl_state_e state_d;
    dcache_pkg::mem_req_t    mem_req_q;
    dcache_pkg::mem_req_t    mem_req_d;
    logic                    mem_valid_q;
    logic                    mem_valid_d;

    logic [INDEX_W-1:0]          req_index;
    logic [TAG_W-1:0]            req_tag;
    logic [1:0]                  hit;
    logic                        hit_any;
    logic                        hit_way;
    logic                        victim;
    logic                        victim_dirty;
    logic                        is_write;
    logic                        full_write;
    logic [dcache_pkg::DATA_W-1:0] fill_word;

    // Core bytes over an old word
    function automatic logic [dcache_pkg::DATA_W-1:0] merge_bytes(
        input logic [dcache_pkg::DATA_W-1:0] old_word,
        input logic [dcache_pkg::DATA_W-1:0] new_word,
        input logic [dcache_pkg::MASK_W-1:0] mask
    );
        logic [dcache_pkg::DATA_W-1:0] result;
        result = old_word;
        for (int b = 0; b < dcache_pkg::MASK_W; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    assign req_index = req_i.addr[INDEX_W-1:0];
    assign req_tag   = req_i.addr[dcache_pkg::ADDR_W-1:INDEX_W];

    assign hit[0]  = valid_i[0] && (tag_i[0] == req_tag);
    assign hit[1]  = valid_i[1] && (tag_i[1] == req_tag);
    assign hit_any = |hit;
    assign hit_way = hit[1];

    // Victim is the LRU way
    assign victim       = lru_i;
    assign victim_dirty = valid_i[victim] && dirty_i[victim];

    assign is_write   = |req_i.mask;
    assign full_write = &req_i.mask;
    assign fill_word  = merge_bytes(mem_rdata_i, req_i.wdata, req_i.mask);

    assign index_o     = req_index;
    assign wtag_o      = req_tag;
    assign rdata_o     = data_i[hit_way];
    assign mem_req_o   = mem_req_q;
    assign mem_valid_o = mem_valid_q;

    always_comb begin
        state_d     = state_q;
        mem_req_d   = mem_req_q;
        mem_valid_d = mem_valid_q;
        stall_o     = 1'b1;
        way_we_o    = 2'b00;
        be_o        = '0;
        wdata_o     = req_i.wdata;
        upd_o       = 1'b0;
        upd_way_o   = victim;
        upd_dirty_o = 1'b1;
        touch_o     = 1'b0;
        touch_way_o = victim;

        unique case (state_q)
            dcache_pkg::ST_IDLE: begin
                stall_o = 1'b0;
                if (req_valid_i) begin
                    if (hit_any) begin
                        touch_o     = 1'b1;
                        touch_way_o = hit_way;
                        if (is_write) begin
                            way_we_o[hit_way] = 1'b1;
                            be_o              = req_i.mask;
                            upd_o             = 1'b1;
                            upd_way_o         = hit_way;
                        end
                    end else if (victim_dirty) begin
                        // Write the victim back first
                        stall_o         = 1'b1;
                        state_d         = dcache_pkg::ST_EVICT;
                        mem_req_d.addr  = {tag_i[victim], req_index};
                        mem_req_d.wdata = data_i[victim];
                        mem_req_d.we    = 1'b1;
                        mem_valid_d     = 1'b1;
                    end else if (full_write) begin
                        // Whole word known, no fetch needed
                        way_we_o[victim] = 1'b1;
                        be_o             = '1;
                        upd_o            = 1'b1;
                        touch_o          = 1'b1;
                    end else begin
                        stall_o        = 1'b1;
                        state_d        = dcache_pkg::ST_FETCH;
                        mem_req_d.addr = req_i.addr;
                        mem_req_d.we   = 1'b0;
                        mem_valid_d    = 1'b1;
                    end
                end
            end

            dcache_pkg::ST_EVICT: begin
                if (mem_ready_i) begin
                    if (full_write) begin
                        way_we_o[victim] = 1'b1;
                        be_o             = '1;
                        upd_o            = 1'b1;
                        state_d          = dcache_pkg::ST_IDLE;
                        mem_valid_d      = 1'b0;
                    end else begin
                        state_d        = dcache_pkg::ST_FETCH;
                        mem_req_d.addr = req_i.addr;
                        mem_req_d.we   = 1'b0;
                    end
                end
            end

            dcache_pkg::ST_FETCH: begin
                if (mem_ready_i) begin
                    // Request retires as a hit next cycle
                    way_we_o[victim] = 1'b1;
                    be_o             = '1;
                    wdata_o          = fill_word;
                    upd_o            = 1'b1;
                    upd_dirty_o      = is_write;
                    state_d          = dcache_pkg::ST_IDLE;
                    mem_valid_d      = 1'b0;
                end
            end

            default: begin
                state_d = dcache_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= dcache_pkg::ST_IDLE;
            mem_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            mem_valid_q <= mem_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        mem_req_q <= mem_req_d;
    end

endmodule

/* verilog/dcache_line_state.sv */
module dcache_line_state #(
    parameter int INDEX_W = 8
) (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic [INDEX_W-1:0] index_i,
    input  logic               upd_i,
    input  logic               upd_way_i,
    input  logic               upd_dirty_i,
    input  logic               touch_i,
    input  logic               touch_way_i,
    output logic [1:0]         valid_o,
    output logic [1:0]         dirty_o,
    output logic               lru_o
);

    localparam int SETS = 1 << INDEX_W;

    // Per set, bit n belongs to way n
    logic [SETS-1:0][1:0] valid_q;
    logic [SETS-1:0][1:0] dirty_q;

    // Way number of the least recently used way
    logic [SETS-1:0]      lru_q;

    assign valid_o = valid_q[index_i];
    assign dirty_o = dirty_q[index_i];
    assign lru_o   = lru_q[index_i];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (upd_i) begin
            // Only the addressed way changes
            valid_q[index_i][upd_way_i] <= 1'b1;
            dirty_q[index_i][upd_way_i] <= upd_dirty_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            lru_q <= '0;
        end else if (touch_i) begin
            lru_q[index_i] <= ~touch_way_i;
        end
    end

endmodule

/* verilog/dcache_pkg.sv */
package dcache_pkg;

    // Core word and byte lanes
    localparam int DATA_W = 32;
    localparam int MASK_W = 4;

    // Word address, byte address bits 18 to 2
    localparam int ADDR_W = 17;

    // Request from the core, a zero mask is a read
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [MASK_W-1:0] mask;
    } core_req_t;

    // Request toward memory, always full-word
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              we;
    } mem_req_t;

    // Controller states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_FETCH = 2'd1,
        ST_EVICT = 2'd2
    } ctrl_state_e;

endpackage

/* verilog/dcache_top.sv */
module dcache_top #(
    parameter int INDEX_W = 8
) (
    input  logic                          clk_i,
    input  logic                          rst_i,

    // Core side
    input  dcache_pkg::core_req_t         req_i,
    input  logic                          req_valid_i,
    output logic [dcache_pkg::DATA_W-1:0] rdata_o,
    output logic                          stall_o,

    // Memory side
    output dcache_pkg::mem_req_t          mem_req_o,
    output logic                          mem_valid_o,
    input  logic [dcache_pkg::DATA_W-1:0] mem_rdata_i,
    input  logic                          mem_ready_i
);

    localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W;

    logic [INDEX_W-1:0]                  index;
    logic [1:0][TAG_W-1:0]               way_tag;
    logic [1:0][dcache_pkg::DATA_W-1:0]  way_data;
    logic [1:0]                          way_we;
    logic [dcache_pkg::MASK_W-1:0]       be;
    logic [TAG_W-1:0]                    wtag;
    logic [dcache_pkg::DATA_W-1:0]       wdata;
    logic [1:0]                          valid;
    logic [1:0]                          dirty;
    logic                                lru;
    logic                                upd;
    logic                                upd_way;
    logic                                upd_dirty;
    logic                                touch;
    logic                                touch_way;

    dcache_ctrl #(
        .INDEX_W(INDEX_W)
    ) i_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .rdata_o     (rdata_o),
        .stall_o     (stall_o),
        .mem_req_o   (mem_req_o),
        .mem_valid_o (mem_valid_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ready_i (mem_ready_i),
        .index_o     (index),
        .tag_i       (way_tag),
        .data_i      (way_data),
        .valid_i     (valid),
        .dirty_i     (dirty),
        .lru_i       (lru),
        .way_we_o    (way_we),
        .be_o        (be),
        .wtag_o      (wtag),
        .wdata_o     (wdata),
        .upd_o       (upd),
        .upd_way_o   (upd_way),
        .upd_dirty_o (upd_dirty),
        .touch_o     (touch),
        .touch_way_o (touch_way)
    );

    dcache_way_ram #(
        .INDEX_W(INDEX_W)
    ) i_way0 (
        .clk_i   (clk_i),
        .index_i (index),
        .we_i    (way_we[0]),
        .be_i    (be),
        .wtag_i  (wtag),
        .wdata_i (wdata),
        .tag_o   (way_tag[0]),
        .data_o  (way_data[0])
    );

    dcache_way_ram #(
        .INDEX_W(INDEX_W)
    ) i_way1 (
        .clk_i   (clk_i),
        .index_i (index),
        .we_i    (way_we[1]),
        .be_i    (be),
        .wtag_i  (wtag),
        .wdata_i (wdata),
        .tag_o   (way_tag[1]),
        .data_o  (way_data[1])
    );

    dcache_line_state #(
        .INDEX_W(INDEX_W)
    ) i_line_state (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .index_i     (index),
        .upd_i       (upd),
        .upd_way_i   (upd_way),
        .upd_dirty_i (upd_dirty),
        .touch_i     (touch),
        .touch_way_i (touch_way),
        .valid_o     (valid),
        .dirty_o     (dirty),
        .lru_o       (lru)
    );

endmodule

/* verilog/dcache_way_ram.sv */
module dcache_way_ram #(
    parameter int INDEX_W = 8
) (
    input  logic                                  clk_i,
    input  logic [INDEX_W-1:0]                    index_i,
    input  logic                                  we_i,
    input  logic [dcache_pkg::MASK_W-1:0]         be_i,
    input  logic [dcache_pkg::ADDR_W-INDEX_W-1:0] wtag_i,
    input  logic [dcache_pkg::DATA_W-1:0]         wdata_i,
    output logic [dcache_pkg::ADDR_W-INDEX_W-1:0] tag_o,
    output logic [dcache_pkg::DATA_W-1:0]         data_o
);

    localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W;
    localparam int SETS  = 1 << INDEX_W;

    logic [TAG_W-1:0]              tag_mem  [SETS];
    logic [dcache_pkg::DATA_W-1:0] data_mem [SETS];

    // Indexed set is visible in the same cycle
    assign tag_o  = tag_mem[index_i];
    assign data_o = data_mem[index_i];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            tag_mem[index_i] <= wtag_i;
            for (int b = 0; b < dcache_pkg::MASK_W; b++) begin
                if (be_i[b]) begin
                    data_mem[index_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule
